// File: hw/cl_hello_pkg.sv
// Hello register target definitions
package cl_hello_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------
  localparam addr_t HELLO_ADDR         = 32'h0000_0500;
  localparam addr_t VLED_ADDR          = 32'h0000_0504;
  localparam addr_t CNT_CTRL_ADDR      = 32'h0000_0508;
  localparam addr_t TICK_VALUE_ADDR    = 32'h0000_050C;
  localparam addr_t CNT_LOAD_ADDR      = 32'h0000_0510;
  localparam addr_t CNT_WATERMARK_ADDR = 32'h0000_0514;
  localparam addr_t CNT_STATUS_ADDR    = 32'h0000_0518;

  localparam data_t      UNMAPPED_VALUE = 32'hDEAD_DEAD;
  localparam logic [1:0] RESP_OKAY      = 2'b00;

  // Counter control bits
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_ONESHOT_BIT = 1;
  localparam int CTRL_CLEAR_BIT   = 2;
  localparam int CTRL_LOAD_BIT    = 3;

  localparam int VLED_WIDTH         = 16;
  localparam int CNT_WIDTH_DEFAULT  = 16;
  localparam int TICK_WIDTH_DEFAULT = 8;

  typedef struct packed {
    logic                          enable;
    logic                          oneshot;
    logic                          clear;
    logic                          load;
    logic [TICK_WIDTH_DEFAULT-1:0] tick_limit;
    logic [CNT_WIDTH_DEFAULT-1:0]  load_value;
    logic [CNT_WIDTH_DEFAULT-1:0]  watermark;
  } cnt_ctrl_t;

  // Field order matches the status register layout
  typedef struct packed {
    logic                          ge_watermark;
    logic [TICK_WIDTH_DEFAULT-1:0] tick_cnt;
    logic [CNT_WIDTH_DEFAULT-1:0]  cnt;
  } cnt_status_t;

endpackage

// File: hw/reg_access_if.sv
// Register access interface
`timescale 1ns/1ps

interface reg_access_if;

  // Write side, one cycle per access
  logic        wr_en;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;

  // Read side, data returned in the rd_en cycle
  logic        rd_en;
  logic [31:0] rd_addr;
  logic [31:0] rd_data;

  modport bus (
    output wr_en, wr_addr, wr_data, rd_en, rd_addr,
    input  rd_data
  );

  modport regs (
    input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
    output rd_data
  );

endinterface

// File: hw/axil_reg_slave.sv
// AXI4-Lite register target
`timescale 1ns/1ps

module axil_reg_slave (
  input  logic                clk_main_a0,
  input  logic                rst_main_n_sync,
  input  logic                awvalid,
  input  cl_hello_pkg::addr_t awaddr,
  output logic                awready,
  input  logic                wvalid,
  input  cl_hello_pkg::data_t wdata,
  output logic                wready,
  output logic                bvalid,
  output logic [1:0]          bresp,
  input  logic                bready,
  input  logic                arvalid,
  input  cl_hello_pkg::addr_t araddr,
  output logic                arready,
  output logic                rvalid,
  output cl_hello_pkg::data_t rdata,
  output logic [1:0]          rresp,
  input  logic                rready,
  reg_access_if.bus           bus
);
  import cl_hello_pkg::*;

  logic  wr_open_q;
  addr_t wr_addr_q;
  logic  rd_pend_q;
  addr_t rd_addr_q;
  logic  aw_xfer;
  logic  w_xfer;
  logic  ar_xfer;

  // ----------------------------------------------------------------------
  // Write channels
  // ----------------------------------------------------------------------
  // New address only once the previous response is gone
  assign awready = !wr_open_q && !bvalid;
  assign wready  = wr_open_q && wvalid;
  assign aw_xfer = awvalid && awready;
  assign w_xfer  = wvalid && wready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_open_q <= 1'b0;
    end else if (aw_xfer) begin
      wr_open_q <= 1'b1;
    end else if (w_xfer) begin
      wr_open_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (aw_xfer) begin
      wr_addr_q <= awaddr;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (w_xfer) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  assign bresp = RESP_OKAY;

  // ----------------------------------------------------------------------
  // Read channels
  // ----------------------------------------------------------------------
  assign arready = !rd_pend_q && !rvalid;
  assign ar_xfer = arvalid && arready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= ar_xfer;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_xfer) begin
      rd_addr_q <= araddr;
    end
  end

  // Data captured from the register file one cycle after the address
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end else if (rd_pend_q) begin
      rvalid <= 1'b1;
      rdata  <= bus.rd_data;
    end
  end

  assign rresp = RESP_OKAY;

  // Register side
  assign bus.wr_en   = w_xfer;
  assign bus.wr_addr = wr_addr_q;
  assign bus.wr_data = wdata;
  assign bus.rd_en   = rd_pend_q;
  assign bus.rd_addr = rd_addr_q;

endmodule

// File: hw/hello_reg_file.sv
// Hello and counter control registers
`timescale 1ns/1ps

module hello_reg_file #(
  parameter int CNT_WIDTH  = cl_hello_pkg::CNT_WIDTH_DEFAULT,
  parameter int TICK_WIDTH = cl_hello_pkg::TICK_WIDTH_DEFAULT
) (
  input  logic                                clk_main_a0,
  input  logic                                rst_main_n_sync,
  reg_access_if.regs                          regs,
  output cl_hello_pkg::cnt_ctrl_t             cnt_ctrl,
  input  cl_hello_pkg::cnt_status_t           cnt_status,
  output logic [cl_hello_pkg::VLED_WIDTH-1:0] hello_low,
  input  logic [cl_hello_pkg::VLED_WIDTH-1:0] vled_shadow
);
  import cl_hello_pkg::*;

  data_t                 hello_q;
  logic                  enable_q;
  logic                  oneshot_q;
  logic                  clear_q;
  logic                  load_q;
  logic [TICK_WIDTH-1:0] tick_limit_q;
  logic [CNT_WIDTH-1:0]  load_value_q;
  logic [CNT_WIDTH-1:0]  watermark_q;
  data_t                 rd_mux;

  // ----------------------------------------------------------------------
  // Register writes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q      <= '0;
      enable_q     <= 1'b0;
      oneshot_q    <= 1'b0;
      clear_q      <= 1'b0;
      load_q       <= 1'b0;
      tick_limit_q <= '0;
      load_value_q <= '0;
      watermark_q  <= '0;
    end else begin
      // Strobes last a single cycle
      clear_q <= 1'b0;
      load_q  <= 1'b0;
      if (regs.wr_en) begin
        case (regs.wr_addr)
          HELLO_ADDR: hello_q <= regs.wr_data;
          CNT_CTRL_ADDR: begin
            enable_q  <= regs.wr_data[CTRL_ENABLE_BIT];
            oneshot_q <= regs.wr_data[CTRL_ONESHOT_BIT];
            clear_q   <= regs.wr_data[CTRL_CLEAR_BIT];
            load_q    <= regs.wr_data[CTRL_LOAD_BIT];
          end
          TICK_VALUE_ADDR:    tick_limit_q <= regs.wr_data[TICK_WIDTH-1:0];
          CNT_LOAD_ADDR:      load_value_q <= regs.wr_data[CNT_WIDTH-1:0];
          CNT_WATERMARK_ADDR: watermark_q  <= regs.wr_data[CNT_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Readback
  // ----------------------------------------------------------------------
  always_comb begin
    case (regs.rd_addr)
      HELLO_ADDR:         rd_mux = {hello_q[7:0], hello_q[15:8],
                                    hello_q[23:16], hello_q[31:24]};
      VLED_ADDR:          rd_mux = data_t'(vled_shadow);
      CNT_CTRL_ADDR:      rd_mux = data_t'({oneshot_q, enable_q});
      TICK_VALUE_ADDR:    rd_mux = data_t'(tick_limit_q);
      CNT_LOAD_ADDR:      rd_mux = data_t'(load_value_q);
      CNT_WATERMARK_ADDR: rd_mux = data_t'(watermark_q);
      CNT_STATUS_ADDR:    rd_mux = data_t'(cnt_status);
      default:            rd_mux = UNMAPPED_VALUE;
    endcase
  end

  assign regs.rd_data = regs.rd_en ? rd_mux : '0;

  // Counter control and LED source
  assign cnt_ctrl.enable     = enable_q;
  assign cnt_ctrl.oneshot    = oneshot_q;
  assign cnt_ctrl.clear      = clear_q;
  assign cnt_ctrl.load       = load_q;
  assign cnt_ctrl.tick_limit = TICK_WIDTH_DEFAULT'(tick_limit_q);
  assign cnt_ctrl.load_value = CNT_WIDTH_DEFAULT'(load_value_q);
  assign cnt_ctrl.watermark  = CNT_WIDTH_DEFAULT'(watermark_q);

  assign hello_low = hello_q[VLED_WIDTH-1:0];

endmodule

// File: hw/vled_mask.sv
// Virtual LED shadow and switch mask
`timescale 1ns/1ps

module vled_mask (
  input  logic                                clk_main_a0,
  input  logic                                rst_main_n_sync,
  input  logic [cl_hello_pkg::VLED_WIDTH-1:0] hello_low,
  input  logic [cl_hello_pkg::VLED_WIDTH-1:0] vdip,
  output logic [cl_hello_pkg::VLED_WIDTH-1:0] vled_shadow,
  output logic [cl_hello_pkg::VLED_WIDTH-1:0] vled
);
  import cl_hello_pkg::*;

  logic [VLED_WIDTH-1:0] vdip_q1;
  logic [VLED_WIDTH-1:0] vdip_q2;

  // Switches are asynchronous, two flops before use
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1     <= '0;
      vdip_q2     <= '0;
      vled_shadow <= '0;
      vled        <= '0;
    end else begin
      vdip_q1     <= vdip;
      vdip_q2     <= vdip_q1;
      vled_shadow <= hello_low;
      vled        <= vled_shadow & vdip_q2;
    end
  end

endmodule

// File: hw/tick_counter.sv
// Prescaled event counter
`timescale 1ns/1ps

module tick_counter #(
  parameter int CNT_WIDTH  = cl_hello_pkg::CNT_WIDTH_DEFAULT,
  parameter int TICK_WIDTH = cl_hello_pkg::TICK_WIDTH_DEFAULT
) (
  input  logic                      clk_main_a0,
  input  logic                      rst_main_n_sync,
  input  cl_hello_pkg::cnt_ctrl_t   cnt_ctrl,
  output cl_hello_pkg::cnt_status_t cnt_status
);
  import cl_hello_pkg::*;

  logic [TICK_WIDTH-1:0] tick_cnt_q;
  logic [CNT_WIDTH-1:0]  cnt_q;
  logic [TICK_WIDTH-1:0] tick_limit;
  logic                  tick;
  logic                  cnt_full;

  assign tick_limit = TICK_WIDTH'(cnt_ctrl.tick_limit);
  assign tick       = tick_cnt_q >= tick_limit;
  assign cnt_full   = &cnt_q;

  // ----------------------------------------------------------------------
  // Prescaler and main counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync || cnt_ctrl.clear) begin
      tick_cnt_q <= '0;
      cnt_q      <= '0;
    end else begin
      if (cnt_ctrl.enable) begin
        tick_cnt_q <= tick ? '0 : tick_cnt_q + 1'b1;
      end
      if (cnt_ctrl.load) begin
        cnt_q <= CNT_WIDTH'(cnt_ctrl.load_value);
      end else if (cnt_ctrl.enable && tick) begin
        // One-shot parks at all ones
        if (!(cnt_ctrl.oneshot && cnt_full)) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign cnt_status.cnt          = CNT_WIDTH_DEFAULT'(cnt_q);
  assign cnt_status.tick_cnt     = TICK_WIDTH_DEFAULT'(tick_cnt_q);
  assign cnt_status.ge_watermark = cnt_q >= CNT_WIDTH'(cnt_ctrl.watermark);

endmodule

// File: hw/cl_hello_top.sv
// Hello register target top level
`timescale 1ns/1ps

module cl_hello_top #(
  parameter int CNT_WIDTH  = cl_hello_pkg::CNT_WIDTH_DEFAULT,
  parameter int TICK_WIDTH = cl_hello_pkg::TICK_WIDTH_DEFAULT
) (
  input  logic                                clk_main_a0,
  input  logic                                rst_main_n_sync,
  input  logic                                awvalid,
  input  cl_hello_pkg::addr_t                 awaddr,
  output logic                                awready,
  input  logic                                wvalid,
  input  cl_hello_pkg::data_t                 wdata,
  output logic                                wready,
  output logic                                bvalid,
  output logic [1:0]                          bresp,
  input  logic                                bready,
  input  logic                                arvalid,
  input  cl_hello_pkg::addr_t                 araddr,
  output logic                                arready,
  output logic                                rvalid,
  output cl_hello_pkg::data_t                 rdata,
  output logic [1:0]                          rresp,
  input  logic                                rready,
  input  logic [cl_hello_pkg::VLED_WIDTH-1:0] vdip,
  output logic [cl_hello_pkg::VLED_WIDTH-1:0] vled
);
  import cl_hello_pkg::*;

  cnt_ctrl_t             cnt_ctrl;
  cnt_status_t           cnt_status;
  logic [VLED_WIDTH-1:0] hello_low;
  logic [VLED_WIDTH-1:0] vled_shadow;

  reg_access_if reg_bus ();

  axil_reg_slave u_axil_reg_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .bus             (reg_bus.bus)
  );

  hello_reg_file #(
    .CNT_WIDTH  (CNT_WIDTH),
    .TICK_WIDTH (TICK_WIDTH)
  ) u_hello_reg_file (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .regs            (reg_bus.regs),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_status      (cnt_status),
    .hello_low       (hello_low),
    .vled_shadow     (vled_shadow)
  );

  vled_mask u_vled_mask (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .vdip            (vdip),
    .vled_shadow     (vled_shadow),
    .vled            (vled)
  );

  tick_counter #(
    .CNT_WIDTH  (CNT_WIDTH),
    .TICK_WIDTH (TICK_WIDTH)
  ) u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_status      (cnt_status)
  );

endmodule

// File: bench/tb_checker.sv
// Register target bus monitor
`timescale 1ns/1ps

module tb_checker (
  input  logic                clk_main_a0,
  input  logic                rst_main_n_sync,
  input  logic                awvalid,
  input  cl_hello_pkg::addr_t awaddr,
  input  logic                awready,
  input  logic                wvalid,
  input  cl_hello_pkg::data_t wdata,
  input  logic                wready,
  input  logic                bvalid,
  input  logic [1:0]          bresp,
  input  logic                bready,
  input  logic                arvalid,
  input  cl_hello_pkg::addr_t araddr,
  input  logic                arready,
  input  logic                rvalid,
  input  cl_hello_pkg::data_t rdata,
  input  logic [1:0]          rresp,
  input  logic                rready,
  input  logic [15:0]         vdip,
  input  logic [15:0]         vled,
  output int                  error_count
);
  import cl_hello_pkg::*;

  localparam int CW = CNT_WIDTH_DEFAULT;
  localparam int TW = TICK_WIDTH_DEFAULT;

  data_t         hello_m;
  logic          enable_m;
  logic          oneshot_m;
  logic          clear_m;
  logic          load_m;
  logic [TW-1:0] tick_limit_m;
  logic [TW-1:0] tick_m;
  logic [CW-1:0] load_value_m;
  logic [CW-1:0] watermark_m;
  logic [CW-1:0] cnt_m;
  logic [15:0]   shadow_m;
  logic [15:0]   sync1_m;
  logic [15:0]   sync2_m;
  logic [15:0]   vled_m;
  addr_t         aw_addr_m;
  addr_t         ar_addr_m;
  logic          aw_open_m;
  logic          b_wait_m;
  logic          rd_pend_m;
  logic          rd_wait_m;
  data_t         rd_exp_m;
  data_t         rdata_prev;
  logic          r_stall;

  task automatic compare_value(input string name, input data_t expected, input data_t actual);
    if (expected !== actual) begin
      error_count++;
      $display("Mismatch %s expected %h got %h", name, expected, actual);
    end
  endtask

  // Register map as seen by the host
  function automatic data_t expected_read(input addr_t addr);
    case (addr)
      HELLO_ADDR:         return {hello_m[7:0], hello_m[15:8], hello_m[23:16], hello_m[31:24]};
      VLED_ADDR:          return {16'h0, shadow_m};
      CNT_CTRL_ADDR:      return {30'h0, oneshot_m, enable_m};
      TICK_VALUE_ADDR:    return {24'h0, tick_limit_m};
      CNT_LOAD_ADDR:      return {16'h0, load_value_m};
      CNT_WATERMARK_ADDR: return {16'h0, watermark_m};
      CNT_STATUS_ADDR:    return {7'h0, cnt_m >= watermark_m, tick_m, cnt_m};
      default:            return UNMAPPED_VALUE;
    endcase
  endfunction

  always @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_m      = '0;
      enable_m     = 1'b0;
      oneshot_m    = 1'b0;
      clear_m      = 1'b0;
      load_m       = 1'b0;
      tick_limit_m = '0;
      tick_m       = '0;
      load_value_m = '0;
      watermark_m  = '0;
      cnt_m        = '0;
      shadow_m     = '0;
      sync1_m      = '0;
      sync2_m      = '0;
      vled_m       = '0;
      aw_open_m    = 1'b0;
      b_wait_m     = 1'b0;
      rd_pend_m    = 1'b0;
      rd_wait_m    = 1'b0;
      r_stall      = 1'b0;
    end else begin
      // ------------------------------------------------------------------
      // Channel checks on values from before the edge
      // ------------------------------------------------------------------
      compare_value("vled", {16'h0, vled_m}, {16'h0, vled});
      compare_value("awready", {31'h0, !(aw_open_m || b_wait_m)}, {31'h0, awready});
      compare_value("wready", {31'h0, aw_open_m && wvalid}, {31'h0, wready});
      compare_value("bvalid", {31'h0, b_wait_m}, {31'h0, bvalid});
      compare_value("arready", {31'h0, !(rd_pend_m || rd_wait_m)}, {31'h0, arready});
      compare_value("rvalid", {31'h0, rd_wait_m}, {31'h0, rvalid});
      if (r_stall) begin
        compare_value("rdata", rdata_prev, rdata);
      end
      if (b_wait_m && bready) begin
        compare_value("bresp", {30'h0, RESP_OKAY}, {30'h0, bresp});
        b_wait_m = 1'b0;
      end
      if (rd_wait_m && rready) begin
        compare_value("rdata", rd_exp_m, rdata);
        compare_value("rresp", {30'h0, RESP_OKAY}, {30'h0, rresp});
        rd_wait_m = 1'b0;
      end

      // Readback is taken the cycle after the address
      if (rd_pend_m) begin
        rd_exp_m  = expected_read(ar_addr_m);
        rd_wait_m = 1'b1;
      end
      rd_pend_m = arvalid && arready;
      if (arvalid && arready) begin
        ar_addr_m = araddr;
      end
      r_stall    = rvalid && !rready;
      rdata_prev = rdata;

      // Counter sees control as it stood before this edge
      if (clear_m) begin
        tick_m = '0;
        cnt_m  = '0;
      end else begin
        if (load_m) begin
          cnt_m = load_value_m;
        end else if (enable_m && tick_m >= tick_limit_m && !(oneshot_m && &cnt_m)) begin
          cnt_m = cnt_m + CW'(1);
        end
        if (enable_m) begin
          tick_m = (tick_m >= tick_limit_m) ? '0 : tick_m + TW'(1);
        end
      end

      // LED path, shadow then two sync flops then output flop
      vled_m   = shadow_m & sync2_m;
      sync2_m  = sync1_m;
      sync1_m  = vdip;
      shadow_m = hello_m[15:0];

      // Register writes land on the w transfer
      clear_m = 1'b0;
      load_m  = 1'b0;
      if (wvalid && wready) begin
        case (aw_addr_m)
          HELLO_ADDR: hello_m = wdata;
          CNT_CTRL_ADDR: begin
            enable_m  = wdata[0];
            oneshot_m = wdata[1];
            clear_m   = wdata[2];
            load_m    = wdata[3];
          end
          TICK_VALUE_ADDR:    tick_limit_m = wdata[TW-1:0];
          CNT_LOAD_ADDR:      load_value_m = wdata[CW-1:0];
          CNT_WATERMARK_ADDR: watermark_m  = wdata[CW-1:0];
          default: ;
        endcase
        aw_open_m = 1'b0;
        b_wait_m  = 1'b1;
      end
      if (awvalid && awready) begin
        aw_addr_m = awaddr;
        aw_open_m = 1'b1;
      end
    end
  end

endmodule

// File: bench/tb_top.sv
// Register target testbench
`timescale 1ns/1ps

module tb_top;
  import cl_hello_pkg::*;

  localparam int TIMEOUT_CYCLES = 64;

  typedef enum {CH_AW, CH_W, CH_B, CH_AR, CH_R} chan_e;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        awvalid;
  addr_t       awaddr;
  logic        awready;
  logic        wvalid;
  data_t       wdata;
  logic        wready;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        bready;
  logic        arvalid;
  addr_t       araddr;
  logic        arready;
  logic        rvalid;
  data_t       rdata;
  logic [1:0]  rresp;
  logic        rready;
  logic [15:0] vdip;
  logic [15:0] vled;
  int          error_count;
  int          timeout_count;

  always #2 clk_main_a0 = ~clk_main_a0;

  cl_hello_top dut (.*);

  tb_checker u_checker (.*);

  // DUT side of each handshake, read just after the rising edge
  function automatic logic channel_done(input chan_e ch);
    case (ch)
      CH_AW:   return awready;
      CH_W:    return wready;
      CH_B:    return bvalid;
      CH_AR:   return arready;
      default: return rvalid;
    endcase
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk_main_a0);
  endtask

  task automatic wait_handshake(input chan_e ch, input string what);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge clk_main_a0);
    while (!channel_done(ch) && wait_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_main_a0);
      wait_cnt++;
    end
    if (!channel_done(ch)) begin
      timeout_count++;
      $display("Timeout waiting for %s", what);
    end
    @(negedge clk_main_a0);
  endtask

  task automatic axi_write(input addr_t addr, input data_t data);
    idle($urandom_range(2));
    awvalid = 1'b1;
    awaddr  = addr;
    wait_handshake(CH_AW, "awready");
    awvalid = 1'b0;
    idle($urandom_range(2));
    wvalid = 1'b1;
    wdata  = data;
    wait_handshake(CH_W, "wready");
    wvalid = 1'b0;
    // Random stretch of bready low
    idle($urandom_range(5));
    bready = 1'b1;
    wait_handshake(CH_B, "bvalid");
    bready = 1'b0;
  endtask

  task automatic axi_read(input addr_t addr);
    idle($urandom_range(2));
    arvalid = 1'b1;
    araddr  = addr;
    wait_handshake(CH_AR, "arready");
    arvalid = 1'b0;
    idle($urandom_range(6));
    rready = 1'b1;
    wait_handshake(CH_R, "rvalid");
    rready = 1'b0;
  endtask

  initial begin
    clk_main_a0     = 1'b0;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    vdip            = '0;
    timeout_count   = 0;
    void'($urandom(76));
    repeat (16) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;

    // Hello byte-swapped readback
    repeat (8) begin
      axi_write(HELLO_ADDR, $urandom());
      axi_read(HELLO_ADDR);
    end

    // Unmapped and read-only addresses
    repeat (6) begin
      axi_read($urandom() | 32'h0001_0000);
      axi_write(VLED_ADDR, $urandom());
      axi_write($urandom() | 32'h0001_0000, $urandom());
    end
    for (int i = 0; i < 7; i++) begin
      axi_read(HELLO_ADDR + 32'(4 * i));
    end

    // LED mask against random switches
    repeat (6) begin
      vdip = 16'($urandom());
      axi_write(HELLO_ADDR, $urandom());
      idle(3);
      axi_read(VLED_ADDR);
    end

    // Load, watermark and clear while disabled
    repeat (4) begin
      axi_write(CNT_CTRL_ADDR, 32'h0);
      axi_write(CNT_LOAD_ADDR, $urandom());
      axi_write(CNT_WATERMARK_ADDR, $urandom());
      axi_write(CNT_CTRL_ADDR, 32'h8);
      axi_read(CNT_STATUS_ADDR);
      axi_write(CNT_CTRL_ADDR, 32'h4);
      axi_read(CNT_STATUS_ADDR);
    end

    // Free running counter
    axi_write(TICK_VALUE_ADDR, 32'($urandom_range(3)));
    axi_write(CNT_CTRL_ADDR, 32'h1);
    repeat (6) axi_read(CNT_STATUS_ADDR);

    // One-shot parks at all ones, normal mode wraps
    axi_write(CNT_CTRL_ADDR, 32'h0);
    axi_write(CNT_LOAD_ADDR, 32'hFFFF);
    axi_write(CNT_CTRL_ADDR, 32'hA);
    axi_write(CNT_CTRL_ADDR, 32'h3);
    repeat (4) axi_read(CNT_STATUS_ADDR);
    axi_write(CNT_CTRL_ADDR, 32'h1);
    repeat (4) axi_read(CNT_STATUS_ADDR);
    axi_read(CNT_CTRL_ADDR);
    axi_read(TICK_VALUE_ADDR);

    idle(4);
    $display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: cl_hello.f
hw/cl_hello_pkg.sv
hw/reg_access_if.sv
hw/axil_reg_slave.sv
hw/hello_reg_file.sv
hw/vled_mask.sv
hw/tick_counter.sv
hw/cl_hello_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_top
FILELIST = cl_hello.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
